/* hdl/stx_config.svh */
`ifndef STX_CONFIG_SVH
`define STX_CONFIG_SVH

// ******************************
// APB address map
// ******************************

// Byte address width of the APB slave
`define STX_ADDR_WIDTH 12

// Word offsets, low two bits always zero
`define STX_REG_DATA 12'h000
`define STX_REG_DIV  12'h004
`define STX_REG_GAP  12'h008

// ******************************
// Transmit path sizing
// ******************************

`define STX_FIFO_DEPTH 8

// Register values after reset
`define STX_DIV_RESET 11'd3
`define STX_GAP_RESET 11'd0

`endif

/* hdl/stx_pkg.sv */
`default_nettype none

package stx_pkg;

	// ******************************
	// Payload and timing types
	// ******************************

	// One transmitted character
	typedef logic [7:0] tx_byte_t;

	// Bit-time divisor and gap length share this width
	typedef logic [10:0] bit_time_t;

	// FIFO occupancy, wide enough to hold the full depth
	typedef logic [3:0] fifo_count_t;

	// ******************************
	// Frame sequencing
	// ******************************

	typedef enum logic [2:0]
	{
		IDLE,
		START,
		DATA,
		STOP,
		GAP
	} tx_state_t;

endpackage

`default_nettype wire

/* hdl/stx_ctrl_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface stx_ctrl_if
	import stx_pkg::*;
();

	// Register block to core
	logic push;
	tx_byte_t push_data;
	logic status_rd;
	bit_time_t divisor;
	bit_time_t gap;

	// Core to register block
	fifo_count_t fifo_count;
	logic fifo_full;
	logic overflow;
	logic busy;

	modport regs
	(
		output push, push_data, status_rd, divisor, gap,
		input fifo_count, fifo_full, overflow, busy
	);

	// Shared by the FIFO and the frame FSM
	modport core
	(
		input push, push_data, status_rd, divisor, gap,
		output fifo_count, fifo_full, overflow, busy
	);

endinterface

`default_nettype wire

/* hdl/stx_apb_regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "stx_config.svh"

module stx_apb_regs
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`STX_ADDR_WIDTH-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	stx_ctrl_if.regs ctrl
);

	logic [`STX_ADDR_WIDTH-1:0] word_off;
	logic aligned;
	logic wr_access;
	logic rd_access;

	// Per-register strobes
	logic data_wr;
	logic data_rd;
	logic div_wr;
	logic gap_wr;

	bit_time_t divisor_q;
	bit_time_t gap_q;
	tx_byte_t status;

	// ******************************
	// Access decode
	// ******************************

	assign word_off = {paddr[`STX_ADDR_WIDTH-1:2], 2'b00};
	assign aligned = (paddr[1:0] == 2'b00);
	assign wr_access = psel && penable && aligned && pwrite;
	assign rd_access = psel && penable && aligned && !pwrite;

	// Count, overflow, spare, full, busy
	assign status = {ctrl.fifo_count, ctrl.overflow, 1'b0, ctrl.fifo_full, ctrl.busy};

	// Never stalls
	assign pready = 1'b1;

	always_comb
	begin
		data_wr = 1'b0;
		data_rd = 1'b0;
		div_wr = 1'b0;
		gap_wr = 1'b0;
		prdata = '0;
		pslverr = 1'b0;
		if (psel)
		begin
			case (word_off)
				`STX_REG_DATA:
				begin
					data_wr = wr_access;
					data_rd = rd_access;
					prdata = 32'(status);
				end
				`STX_REG_DIV:
				begin
					div_wr = wr_access;
					prdata = 32'(divisor_q);
				end
				`STX_REG_GAP:
				begin
					gap_wr = wr_access;
					prdata = 32'(gap_q);
				end
				default:
					pslverr = aligned;
			endcase
		end
	end

	// ******************************
	// Configuration registers
	// ******************************

	always_ff @(posedge rvx_port_16, negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			divisor_q <= `STX_DIV_RESET;
			gap_q <= `STX_GAP_RESET;
		end
		else
		begin
			if (div_wr)
				divisor_q <= pwdata[10:0];
			if (gap_wr)
				gap_q <= pwdata[10:0];
		end
	end

	assign ctrl.divisor = divisor_q;
	assign ctrl.gap = gap_q;

	// Writes to DATA feed the FIFO, reads of DATA clear overflow
	assign ctrl.push = data_wr;
	assign ctrl.push_data = pwdata[7:0];
	assign ctrl.status_rd = data_rd;

	// APB access phase only with the slave selected
	a_enable_sel: assert property (@(posedge rvx_port_16) disable iff (!rvx_port_04)
		penable |-> psel)
		else $error("penable high without psel");

endmodule

`default_nettype wire

/* hdl/stx_byte_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

`include "stx_config.svh"

module stx_byte_fifo
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	stx_ctrl_if.core ctrl,

	input logic pop,
	output tx_byte_t head,
	output logic empty
);

	localparam int DEPTH = `STX_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	tx_byte_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	fifo_count_t count;
	logic full;
	logic wr_en;
	logic overflow_q;

	assign full = (count == fifo_count_t'(DEPTH));
	assign empty = (count == '0);

	// A pop in the same cycle frees a slot, so a push at full still lands
	assign wr_en = ctrl.push && (!full || pop);

	assign head = mem[rd_ptr];

	always_ff @(posedge rvx_port_16)
	begin
		if (wr_en)
			mem[wr_ptr] <= ctrl.push_data;
	end

	// ******************************
	// Pointers and occupancy
	// ******************************

	always_ff @(posedge rvx_port_16, negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow_q <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// Dropped byte wins over a clear
			if (ctrl.push && !wr_en)
				overflow_q <= 1'b1;
			else if (ctrl.status_rd)
				overflow_q <= 1'b0;
		end
	end

	assign ctrl.fifo_count = count;
	assign ctrl.fifo_full = full;
	assign ctrl.overflow = overflow_q;

	a_no_pop_empty: assert property (@(posedge rvx_port_16) disable iff (!rvx_port_04)
		pop |-> !empty)
		else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* hdl/stx_bit_timer.sv */
`default_nettype none
`timescale 1ns/1ps

module stx_bit_timer
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	input logic load,
	input logic run,
	input bit_time_t period,
	output logic bit_done
);

	bit_time_t count;

	// Last cycle of the current bit-time
	assign bit_done = run && (count == '0);

	always_ff @(posedge rvx_port_16, negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			count <= '0;
		else if (load)
			count <= period;
		else if (run)
		begin
			// Period+1 cycles per bit, zero included
			if (count == '0)
				count <= period;
			else
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/stx_frame_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module stx_frame_fsm
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	stx_ctrl_if.core ctrl,

	input logic empty,
	output logic pop,

	output logic load,
	output logic run,
	output bit_time_t period,
	input logic bit_done,

	output logic load_frame,
	output logic shift
);

	tx_state_t state;
	tx_state_t state_nxt;
	bit_time_t div_q;
	bit_time_t gap_q;
	bit_time_t gap_cnt;
	logic [2:0] bit_cnt;
	logic last_bit;

	// End of stop bit, or of the final gap bit-time
	assign last_bit = bit_done &&
		(((state == STOP) && (gap_q == '0)) || ((state == GAP) && (gap_cnt == 11'd1)));

	// Chaining on last_bit keeps frames back to back
	assign pop = !empty && ((state == IDLE) || last_bit);

	assign load = pop;
	assign load_frame = pop;
	assign run = (state != IDLE);
	assign period = pop ? ctrl.divisor : div_q;
	assign shift = bit_done && ((state == START) || (state == DATA) || (state == STOP));

	assign ctrl.busy = (state != IDLE);

	// ******************************
	// Next state
	// ******************************

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (pop)
					state_nxt = START;
			START:
				if (bit_done)
					state_nxt = DATA;
			DATA:
				if (bit_done && (bit_cnt == 3'd7))
					state_nxt = STOP;
			STOP:
				if (bit_done)
				begin
					if (gap_q != '0)
						state_nxt = GAP;
					else
						state_nxt = pop ? START : IDLE;
				end
			GAP:
				if (last_bit)
					state_nxt = pop ? START : IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge rvx_port_16, negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			state <= IDLE;
			div_q <= '0;
			gap_q <= '0;
			gap_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			state <= state_nxt;
			// Settings frozen for the whole frame
			if (pop)
			begin
				div_q <= ctrl.divisor;
				gap_q <= ctrl.gap;
			end
			if (bit_done)
			begin
				case (state)
					START: bit_cnt <= '0;
					DATA: bit_cnt <= bit_cnt + 3'd1;
					STOP: gap_cnt <= gap_q;
					GAP: gap_cnt <= gap_cnt - 1'b1;
					default: ;
				endcase
			end
		end
	end

	a_done_active: assert property (@(posedge rvx_port_16) disable iff (!rvx_port_04)
		bit_done |-> (state != IDLE))
		else $error("bit timer expired while idle");

endmodule

`default_nettype wire

/* hdl/stx_shifter.sv */
`default_nettype none
`timescale 1ns/1ps

module stx_shifter
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	input logic load_frame,
	input tx_byte_t data,
	input logic shift,
	output logic txd
);

	localparam int FRAME_W = 10;

	// Stop bit, data LSB first, start bit at the bottom
	logic [FRAME_W-1:0] frame;

	always_ff @(posedge rvx_port_16, negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			frame <= '1;
		else if (load_frame)
			frame <= {1'b1, data, 1'b0};
		else if (shift)
			frame <= {1'b1, frame[FRAME_W-1:1]};
	end

	// Ones shifted in keep the line at mark after the stop bit
	assign txd = frame[0];

endmodule

`default_nettype wire

/* hdl/serial_tx.sv */
`default_nettype none
`timescale 1ns/1ps

`include "stx_config.svh"

module serial_tx
	import stx_pkg::*;
(
	input logic rvx_port_16,
	input logic rvx_port_04,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`STX_ADDR_WIDTH-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	output logic txd
);

	logic fifo_pop;
	logic fifo_empty;
	tx_byte_t fifo_head;
	logic tmr_load;
	logic tmr_run;
	bit_time_t tmr_period;
	logic bit_done;
	logic load_frame;
	logic shift;

	stx_ctrl_if ctrl ();

	// ******************************
	// Register block
	// ******************************

	stx_apb_regs u_regs
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ctrl(ctrl)
	);

	// ******************************
	// Transmit core
	// ******************************

	stx_byte_fifo u_fifo
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.ctrl(ctrl),
		.pop(fifo_pop), .head(fifo_head), .empty(fifo_empty)
	);

	stx_frame_fsm u_fsm
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.ctrl(ctrl),
		.empty(fifo_empty), .pop(fifo_pop),
		.load(tmr_load), .run(tmr_run), .period(tmr_period), .bit_done(bit_done),
		.load_frame(load_frame), .shift(shift)
	);

	stx_bit_timer u_timer
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.load(tmr_load), .run(tmr_run), .period(tmr_period), .bit_done(bit_done)
	);

	stx_shifter u_shifter
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.load_frame(load_frame), .data(fifo_head), .shift(shift), .txd(txd)
	);

endmodule

`default_nettype wire

/* bench/stx_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module stx_clock_gen
#(
	parameter real HALF_PERIOD = 2.0,
	parameter int RESET_CYCLES = 10
)
(
	output logic rvx_port_16,
	output logic rvx_port_04
);

	initial
	begin
		rvx_port_16 = 1'b0;
		forever
			#(HALF_PERIOD) rvx_port_16 = ~rvx_port_16;
	end

	// Release lands 1 ns after an edge, clear of the flop sampling point
	initial
	begin
		rvx_port_04 = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge rvx_port_16);
		#1;
		rvx_port_04 = 1'b1;
	end

endmodule

`default_nettype wire

/* bench/serial_tx_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "stx_config.svh"

module serial_tx_tb
	import stx_pkg::*;
();

	localparam logic [31:0] SEED = 32'h50bc;
	localparam int BURST_LEN = 5;
	localparam int FLOOD_LEN = 12;
	localparam int FLOOD_DIV = 40;
	// Frames of the single, burst and overflow tests, plus register traffic
	localparam int FRAME_CYCLES = 10 * (2 + 6 + 13) + BURST_LEN * 10 * 4 + BURST_LEN * 12 * 4
		+ (`STX_FIFO_DEPTH + 1) * 10 * (FLOOD_DIV + 1);
	localparam int REG_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = 2 * (FRAME_CYCLES + REG_CYCLES);

	logic rvx_port_16;
	logic rvx_port_04;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`STX_ADDR_WIDTH-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic txd;

	// Reference model state
	bit_time_t ref_div;
	bit_time_t ref_gap;
	logic [31:0] wr_words [FLOOD_LEN];
	tx_byte_t exp_q [$];
	int frames_expected;
	int exp_fifo_count;
	logic exp_ovf;
	int exp_spacing;

	int cycle;
	int frames_seen;
	int starts [64];

	stx_clock_gen u_clk (.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04));

	serial_tx uut
	(
		.rvx_port_16(rvx_port_16), .rvx_port_04(rvx_port_04),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.txd(txd)
	);

	// ******************************
	// Reference functions
	// ******************************

	// Registers keep the low 11 bits of the write data
	function automatic logic [31:0] reg_value(input logic [31:0] data);
		return {21'd0, data[10:0]};
	endfunction

	function automatic logic [7:0] status_byte(input int count, input logic ovf,
		input logic busy);
		return {fifo_count_t'(count), ovf, 1'b0, (count == `STX_FIFO_DEPTH), busy};
	endfunction

	// Idle core takes the first byte at once, the FIFO keeps the next ones up to its depth
	function automatic void predict_burst(input int n);
		int kept;
		int i;
		kept = (n > `STX_FIFO_DEPTH + 1) ? `STX_FIFO_DEPTH + 1 : n;
		for (i = 0; i < kept; i++)
			exp_q.push_back(wr_words[i][7:0]);
		frames_expected = frames_expected + kept;
		exp_fifo_count = kept - 1;
		exp_ovf = (n > kept);
		exp_spacing = (10 + ref_gap) * (ref_div + 1);
	endfunction

	// ******************************
	// Checks and bus tasks
	// ******************************

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
		input string name);
		if (actual !== expected)
		begin
			$display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			stop_on_error();
		end
	endtask

	// Called 1 ns after a rising edge, returns 1 ns after the access edge
	task automatic write_reg(input logic [`STX_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		input logic exp_err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge rvx_port_16);
		#1;
		penable = 1'b1;
		@(negedge rvx_port_16);
		check_value(1'b1, pready, "pready");
		check_value(exp_err, pslverr, "pslverr");
		@(posedge rvx_port_16);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_reg(input logic [`STX_ADDR_WIDTH-1:0] addr, input logic exp_err,
		output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge rvx_port_16);
		#1;
		penable = 1'b1;
		@(negedge rvx_port_16);
		check_value(1'b1, pready, "pready");
		check_value(exp_err, pslverr, "pslverr");
		data = prdata;
		@(posedge rvx_port_16);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_reg(input logic [`STX_ADDR_WIDTH-1:0] addr,
		input logic [31:0] expected, input string name);
		logic [31:0] data;
		read_reg(addr, 1'b0, data);
		check_value(expected, data, name);
	endtask

	task automatic set_timing(input logic [31:0] div, input logic [31:0] gap);
		write_reg(`STX_REG_DIV, div, 1'b0);
		write_reg(`STX_REG_GAP, gap, 1'b0);
		ref_div = bit_time_t'(reg_value(div));
		ref_gap = bit_time_t'(reg_value(gap));
	endtask

	task automatic send_burst(input int n);
		int i;
		for (i = 0; i < n; i++)
			wr_words[i] = $urandom;
		predict_burst(n);
		for (i = 0; i < n; i++)
			write_reg(`STX_REG_DATA, wr_words[i], 1'b0);
	endtask

	// Done when the decoder has seen every predicted frame
	task automatic wait_drained();
		@(posedge rvx_port_16);
		while (frames_seen < frames_expected)
			@(posedge rvx_port_16);
		#1;
	endtask

	task automatic wait_idle();
		logic [31:0] data;
		read_reg(`STX_REG_DATA, 1'b0, data);
		while (data[0] !== 1'b0)
			read_reg(`STX_REG_DATA, 1'b0, data);
	endtask

	// ******************************
	// txd frame decoder
	// ******************************

	initial
	begin : decoder
		tx_byte_t exp_byte;
		tx_byte_t got;
		logic bit_val;
		int span;
		int b;
		int c;
		wait (rvx_port_04 === 1'b1);
		forever
		begin
			@(negedge rvx_port_16);
			if (txd !== 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					$display("Start bit on txd at %0t while no byte was queued", $time);
					stop_on_error();
				end
				starts[frames_seen] = cycle;
				exp_byte = exp_q.pop_front();
				span = ref_div + 1;
				got = '0;
				bit_val = 1'b0;
				// Each bit is sampled every cycle and must hold for its whole bit-time
				for (b = 0; b < 10; b++)
				begin
					for (c = 0; c < span; c++)
					begin
						if (b != 0 || c != 0)
							@(negedge rvx_port_16);
						if (c == 0)
							bit_val = txd;
						else
							check_value(bit_val, txd, "txd");
					end
					if (b == 0)
						check_value(1'b0, bit_val, "txd start bit");
					else if (b == 9)
						check_value(1'b1, bit_val, "txd stop bit");
					else
						got[b-1] = bit_val;
				end
				check_value(exp_byte, got, "txd data byte");
				frames_seen = frames_seen + 1;
			end
		end
	end

	initial
	begin : watchdog
		cycle = 0;
		while (cycle < TIMEOUT_CYCLES)
		begin
			@(posedge rvx_port_16);
			cycle = cycle + 1;
		end
		$display("Timeout after %0d cycles, the expected frames never finished", cycle);
		stop_on_error();
	end

	// ******************************
	// Stimulus
	// ******************************

	initial
	begin : stimulus
		logic [31:0] word;
		int k;
		int i;
		int first;
		frames_seen = 0;
		frames_expected = 0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ref_div = `STX_DIV_RESET;
		ref_gap = `STX_GAP_RESET;
		word = $urandom(SEED);
		wait (rvx_port_04 === 1'b1);
		@(posedge rvx_port_16);
		#1;

		// Reset values, then masked readback
		check_value(1'b1, txd, "txd");
		expect_reg(`STX_REG_DIV, ref_div, "DIVISOR");
		expect_reg(`STX_REG_GAP, ref_gap, "GAP");
		expect_reg(`STX_REG_DATA, status_byte(0, 1'b0, 1'b0), "status");
		for (k = 0; k < 4; k++)
		begin
			set_timing($urandom, $urandom);
			expect_reg(`STX_REG_DIV, ref_div, "DIVISOR");
			expect_reg(`STX_REG_GAP, ref_gap, "GAP");
		end

		// Unmapped offsets flag an error, misaligned ones are ignored
		write_reg(12'h00C, 32'h5a, 1'b1);
		write_reg(12'hFFC, 32'h5a, 1'b1);
		read_reg(12'h010, 1'b1, word);
		write_reg(12'h005, 32'h1, 1'b0);
		write_reg(12'h001, 32'h66, 1'b0);
		write_reg(12'h00E, 32'h5a, 1'b0);
		expect_reg(`STX_REG_DIV, ref_div, "DIVISOR");
		expect_reg(`STX_REG_GAP, ref_gap, "GAP");
		expect_reg(`STX_REG_DATA, status_byte(0, 1'b0, 1'b0), "status");

		// Single frames at several bit-times
		for (k = 0; k < 3; k++)
		begin
			set_timing((k == 0) ? 1 : (k == 1) ? 5 : 12, 0);
			send_burst(1);
			wait_drained();
			wait_idle();
		end

		// Bursts without and with idle gap
		for (k = 0; k < 2; k++)
		begin
			set_timing(3, k * 2);
			first = frames_seen;
			send_burst(BURST_LEN);
			expect_reg(`STX_REG_DATA, status_byte(exp_fifo_count, exp_ovf, 1'b1), "status");
			wait_drained();
			for (i = 1; i < BURST_LEN; i++)
				check_value(exp_spacing, starts[first+i] - starts[first+i-1], "start spacing");
			wait_idle();
		end

		// Overflow: nine bytes kept, three dropped
		set_timing(FLOOD_DIV, 0);
		send_burst(FLOOD_LEN);
		expect_reg(`STX_REG_DATA, status_byte(exp_fifo_count, exp_ovf, 1'b1), "status");
		exp_ovf = 1'b0;
		expect_reg(`STX_REG_DATA, status_byte(exp_fifo_count, exp_ovf, 1'b1), "status");
		wait_drained();
		wait_idle();
		expect_reg(`STX_REG_DATA, status_byte(0, 1'b0, 1'b0), "status");
		check_value(1'b1, txd, "txd");

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* serial_tx.f */
+incdir+hdl
hdl/stx_pkg.sv
hdl/stx_ctrl_if.sv
hdl/stx_apb_regs.sv
hdl/stx_byte_fifo.sv
hdl/stx_bit_timer.sv
hdl/stx_frame_fsm.sv
hdl/stx_shifter.sv
hdl/serial_tx.sv
bench/stx_clock_gen.sv
bench/serial_tx_tb.sv
